/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_risk_top
FILELIST = project.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* client_store.sv */
`timescale 1ns/1ps
// backing store of client records for one bank
// answers each req with a ready pulse exactly store_lat cycles later
// writes land at the request and read data is valid with ready

module client_store (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                req,     // one-cycle request
  input  logic                                we,
  input  logic [risk_pkg::store_addr_w-1:0]   addr,    // {tag, index}
  input  logic [risk_pkg::rec_w-1:0]          wdata,
  output logic [risk_pkg::rec_w-1:0]          rdata,
  output logic                                ready
);

  typedef logic [$clog2(risk_pkg::store_lat+1)-1:0] cnt_t;

  logic [risk_pkg::rec_w-1:0]        mem [2**risk_pkg::store_addr_w];
  logic [risk_pkg::store_addr_w-1:0] addr_r;  // read address held for the reply
  cnt_t                              cnt;     // cycles left until ready

  // latency counter and ready strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt   <= '0;
      ready <= 1'b0;
    end else begin
      ready <= (cnt == 1);  // last count -> reply next cycle
      if (req) begin
        cnt <= cnt_t'(risk_pkg::store_lat - 1);
      end else if (cnt != 0) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // record array cleared to zero on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**risk_pkg::store_addr_w; i++) begin
        mem[i] <= '0;
      end
    end else if (req && we) begin
      mem[addr] <= wdata;  // commit right away
    end
  end

  // read path sampled so it lines up with ready
  always_ff @(posedge clk) begin
    if (req) addr_r <= addr;
    if (cnt == 1) rdata <= mem[addr_r];
  end

endmodule

/* order_dispatch.sv */
`timescale 1ns/1ps
// order dispatcher: takes one order per cycle when its bank is free
// and launches it one cycle later with a one-hot start pulse
// launch fields stay put until the next accepted order

module order_dispatch (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             in_valid,
  input  risk_pkg::op_e                    in_op,
  input  logic [risk_pkg::client_w-1:0]    in_client,
  input  logic [risk_pkg::amt_w-1:0]       in_amount,
  input  logic [risk_pkg::num_banks-1:0]   busy,      // per bank level
  output logic                             in_ready,
  output logic [risk_pkg::num_banks-1:0]   start,     // one-hot pulse
  output risk_pkg::op_e                    launch_op,
  output logic [risk_pkg::client_w-1:0]    launch_client,
  output logic [risk_pkg::amt_w-1:0]       launch_amount
);

  logic [risk_pkg::bank_w-1:0] bank_sel;
  logic                        accept;

  // bank comes straight from the low client bits
  assign bank_sel = in_client[risk_pkg::bank_w-1:0];

  // bank busy, or launch to it going out right now (busy rises a cycle later)
  assign in_ready = !busy[bank_sel] && !start[bank_sel];
  assign accept   = in_valid && in_ready;

  // start strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      start <= '0;
    end else if (accept) begin
      start <= risk_pkg::num_banks'(1) << bank_sel;
    end else begin
      start <= '0;  // pulse lasts one cycle
    end
  end

  // shared launch lines, payload only
  always_ff @(posedge clk) begin
    if (accept) begin
      launch_op     <= in_op;
      launch_client <= in_client;
      launch_amount <= in_amount;
    end
  end

endmodule

/* project.f */
risk_pkg.sv
order_dispatch.sv
client_store.sv
risk_bank.sv
result_collect.sv
risk_top.sv
tb_risk_top.sv

/* result_collect.sv */
`timescale 1ns/1ps
// result collector: round-robin over banks holding a result, one per cycle
// take goes back to the picked bank, its fields appear on the output
// with out_valid on the next cycle

module result_collect (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [risk_pkg::num_banks-1:0]   done,
  input  logic [risk_pkg::client_w-1:0]    res_client [risk_pkg::num_banks],
  input  risk_pkg::res_e                   res_res    [risk_pkg::num_banks],
  input  logic [risk_pkg::amt_w-1:0]       res_max    [risk_pkg::num_banks],
  input  logic [risk_pkg::amt_w-1:0]       res_acc    [risk_pkg::num_banks],
  output logic [risk_pkg::num_banks-1:0]   take,
  output logic                             out_valid,
  output logic [risk_pkg::client_w-1:0]    out_client,
  output risk_pkg::res_e                   out_res,
  output logic [risk_pkg::amt_w-1:0]       out_max,
  output logic [risk_pkg::amt_w-1:0]       out_acc
);

  logic [risk_pkg::bank_w-1:0] ptr;    // first bank to look at
  logic [risk_pkg::bank_w-1:0] sel;
  logic                        found;

  // first done bank at or after ptr, wrapping
  always_comb begin
    logic [risk_pkg::bank_w-1:0] cand;
    found = 1'b0;
    sel   = ptr;
    for (int i = 0; i < risk_pkg::num_banks; i++) begin
      cand = ptr + risk_pkg::bank_w'(i);
      if (!found && done[cand]) begin
        found = 1'b1;
        sel   = cand;
      end
    end
  end

  // bank drops done on the edge after take
  assign take = found ? (risk_pkg::num_banks'(1) << sel) : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr       <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= found;
      if (found) ptr <= sel + 1'b1;  // skip past the winner
    end
  end

  always_ff @(posedge clk) begin
    if (found) begin
      out_client <= res_client[sel];
      out_res    <= res_res[sel];
      out_max    <= res_max[sel];
      out_acc    <= res_acc[sel];
    end
  end

endmodule

/* risk_bank.sv */
`timescale 1ns/1ps
// one risk bank: direct-mapped write-back cache of client records
// in front of its own client store. holds one order from start until
// the collector pulses take; hit -> done after compare, misses go
// through write back and allocate and compare again

module risk_bank (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             start,     // launch strobe for this bank
  input  risk_pkg::op_e                    launch_op,
  input  logic [risk_pkg::client_w-1:0]    launch_client,
  input  logic [risk_pkg::amt_w-1:0]       launch_amount,
  input  logic                             take,      // result consumed
  output logic                             busy,
  output logic                             done,
  output logic [risk_pkg::client_w-1:0]    res_client,
  output risk_pkg::res_e                   res_res,
  output logic [risk_pkg::amt_w-1:0]       res_max,
  output logic [risk_pkg::amt_w-1:0]       res_acc
);

  risk_pkg::bank_state_e state, state_nxt;

  // order held for the whole transaction
  risk_pkg::op_e                 op_r;
  logic [risk_pkg::amt_w-1:0]    amount_r;

  // cache arrays, one record per line
  logic                          valid_arr [2**risk_pkg::index_w];
  logic                          dirty_arr [2**risk_pkg::index_w];
  logic [risk_pkg::tag_w-1:0]    tag_arr   [2**risk_pkg::index_w];
  logic [risk_pkg::rec_w-1:0]    rec_arr   [2**risk_pkg::index_w];

  logic [risk_pkg::index_w-1:0]  idx;
  logic [risk_pkg::tag_w-1:0]    tag;
  logic                          hit;

  // risk rule
  logic [risk_pkg::rec_w-1:0]    line;
  logic [risk_pkg::amt_w-1:0]    cur_max, cur_acc;
  logic [risk_pkg::amt_w:0]      sum;     // one extra bit, no wrap
  logic                          fits;
  logic [risk_pkg::amt_w-1:0]    new_max, new_acc;
  risk_pkg::res_e                new_res;
  logic                          changed;

  // store side
  logic                              st_req, st_we, st_ready;
  logic [risk_pkg::store_addr_w-1:0] st_addr;
  logic [risk_pkg::rec_w-1:0]        st_wdata, st_rdata;

  assign idx  = res_client[risk_pkg::bank_w +: risk_pkg::index_w];
  assign tag  = res_client[risk_pkg::bank_w + risk_pkg::index_w +: risk_pkg::tag_w];
  assign hit  = valid_arr[idx] && (tag_arr[idx] == tag);
  assign busy = (state != risk_pkg::st_idle);
  assign done = (state == risk_pkg::st_hold);

  always_comb begin
    line    = rec_arr[idx];
    cur_max = line[risk_pkg::rec_w-1 -: risk_pkg::amt_w];
    cur_acc = line[risk_pkg::amt_w-1:0];
    sum     = {1'b0, cur_acc} + {1'b0, amount_r};
    fits    = (sum <= {1'b0, cur_max});
    new_max = cur_max;
    new_acc = cur_acc;
    new_res = risk_pkg::res_info;  // query leaves it all alone
    case (op_r)
      risk_pkg::op_set_max: begin
        new_max = amount_r;   // acc kept
        new_res = risk_pkg::res_accept;
      end
      risk_pkg::op_add_order: begin
        if (fits) begin
          new_acc = sum[risk_pkg::amt_w-1:0];
          new_res = risk_pkg::res_accept;
        end else begin
          new_res = risk_pkg::res_reject;
        end
      end
      default: ;
    endcase
    changed = ({new_max, new_acc} != line);
  end

  // next state and store request
  always_comb begin
    state_nxt = state;
    st_req    = 1'b0;
    st_we     = 1'b0;
    st_addr   = {tag, idx};       // refill address by default
    st_wdata  = rec_arr[idx];
    case (state)
      risk_pkg::st_idle:       if (start) state_nxt = risk_pkg::st_compare;
      risk_pkg::st_compare: begin
        if (hit) begin
          state_nxt = risk_pkg::st_hold;
        end else if (valid_arr[idx] && dirty_arr[idx]) begin
          st_req    = 1'b1;
          st_we     = 1'b1;
          st_addr   = {tag_arr[idx], idx};  // victim's own address
          state_nxt = risk_pkg::st_write_back;
        end else begin
          st_req    = 1'b1;       // clean or empty line, just fetch
          state_nxt = risk_pkg::st_allocate;
        end
      end
      // victim now clean, compare again and fetch from there
      risk_pkg::st_write_back: if (st_ready) state_nxt = risk_pkg::st_compare;
      risk_pkg::st_allocate:   if (st_ready) state_nxt = risk_pkg::st_compare;
      risk_pkg::st_hold:       if (take) state_nxt = risk_pkg::st_idle;
      default:                 state_nxt = risk_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= risk_pkg::st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // order latch and result regs
  always_ff @(posedge clk) begin
    if (state == risk_pkg::st_idle && start) begin
      op_r       <= launch_op;
      res_client <= launch_client;
      amount_r   <= launch_amount;
    end
    if (state == risk_pkg::st_compare && hit) begin
      res_res <= new_res;
      res_max <= new_max;
      res_acc <= new_acc;
    end
  end

  // line status bits
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**risk_pkg::index_w; i++) begin
        valid_arr[i] <= 1'b0;
        dirty_arr[i] <= 1'b0;
      end
    end else begin
      case (state)
        risk_pkg::st_compare:
          if (hit && changed) dirty_arr[idx] <= 1'b1;
        risk_pkg::st_write_back:
          if (st_ready) dirty_arr[idx] <= 1'b0;
        risk_pkg::st_allocate:
          if (st_ready) begin
            valid_arr[idx] <= 1'b1;
            dirty_arr[idx] <= 1'b0;  // fresh copy of the store
          end
        default: ;
      endcase
    end
  end

  // tags and records
  always_ff @(posedge clk) begin
    if (state == risk_pkg::st_compare && hit) begin
      rec_arr[idx] <= {new_max, new_acc};
    end
    if (state == risk_pkg::st_allocate && st_ready) begin
      rec_arr[idx] <= st_rdata;
      tag_arr[idx] <= tag;
    end
  end

  client_store u_store (
    .clk   (clk),
    .rst   (rst),
    .req   (st_req),
    .we    (st_we),
    .addr  (st_addr),
    .wdata (st_wdata),
    .rdata (st_rdata),
    .ready (st_ready)
  );

endmodule

/* risk_pkg.sv */
// shared sizes, latencies and enums for the pre-trade risk checker
// every design file refers to these by scoped name, risk_pkg::name

package risk_pkg;

  // bank split
  localparam int num_banks = 4;
  localparam int bank_w    = 2;    // client bits 1:0

  // client id layout, tag | index | bank
  localparam int client_w  = 8;
  localparam int index_w   = 3;    // 8 lines per bank
  localparam int tag_w     = 3;

  // store address is tag then index
  localparam int store_addr_w = tag_w + index_w;

  // record is {max, acc}
  localparam int amt_w = 16;
  localparam int rec_w = 2 * amt_w;

  localparam int store_lat = 5;    // cycles from req to ready

  typedef enum logic [1:0] {
    op_set_max   = 2'd0,  // replace max, keep acc
    op_add_order = 2'd1,  // add amount if it still fits
    op_query     = 2'd2   // read back only
  } op_e;

  typedef enum logic [1:0] {
    res_accept = 2'd0,
    res_reject = 2'd1,    // over limit, record untouched
    res_info   = 2'd2
  } res_e;

  // bank controller states
  typedef enum logic [2:0] {
    st_idle       = 3'd0,
    st_compare    = 3'd1,  // tag check and risk rule
    st_write_back = 3'd2,  // dirty victim to store
    st_allocate   = 3'd3,  // refill from store
    st_hold       = 3'd4   // result waits for take
  } bank_state_e;

endpackage

/* risk_top.sv */
`timescale 1ns/1ps
// top of the pre-trade risk checker
// dispatcher -> four banks (by client id low bits) -> collector
// in_ready is checked per order; out_valid marks each finished result

module risk_top (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             in_valid,
  input  risk_pkg::op_e                    in_op,
  input  logic [risk_pkg::client_w-1:0]    in_client,
  input  logic [risk_pkg::amt_w-1:0]       in_amount,
  output logic                             in_ready,
  output logic                             out_valid,
  output logic [risk_pkg::client_w-1:0]    out_client,
  output risk_pkg::res_e                   out_res,
  output logic [risk_pkg::amt_w-1:0]       out_max,
  output logic [risk_pkg::amt_w-1:0]       out_acc
);

  logic [risk_pkg::num_banks-1:0] start, busy, done, take;

  // shared launch lines
  risk_pkg::op_e                 launch_op;
  logic [risk_pkg::client_w-1:0] launch_client;
  logic [risk_pkg::amt_w-1:0]    launch_amount;

  // per bank results
  logic [risk_pkg::client_w-1:0] res_client [risk_pkg::num_banks];
  risk_pkg::res_e                res_res    [risk_pkg::num_banks];
  logic [risk_pkg::amt_w-1:0]    res_max    [risk_pkg::num_banks];
  logic [risk_pkg::amt_w-1:0]    res_acc    [risk_pkg::num_banks];

  order_dispatch u_dispatch (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .in_op         (in_op),
    .in_client     (in_client),
    .in_amount     (in_amount),
    .busy          (busy),
    .in_ready      (in_ready),
    .start         (start),
    .launch_op     (launch_op),
    .launch_client (launch_client),
    .launch_amount (launch_amount)
  );

  for (genvar k = 0; k < risk_pkg::num_banks; k++) begin : g_bank
    risk_bank u_bank (
      .clk           (clk),
      .rst           (rst),
      .start         (start[k]),
      .launch_op     (launch_op),
      .launch_client (launch_client),
      .launch_amount (launch_amount),
      .take          (take[k]),
      .busy          (busy[k]),
      .done          (done[k]),
      .res_client    (res_client[k]),
      .res_res       (res_res[k]),
      .res_max       (res_max[k]),
      .res_acc       (res_acc[k])
    );
  end

  result_collect u_collect (
    .clk        (clk),
    .rst        (rst),
    .done       (done),
    .res_client (res_client),
    .res_res    (res_res),
    .res_max    (res_max),
    .res_acc    (res_acc),
    .take       (take),
    .out_valid  (out_valid),
    .out_client (out_client),
    .out_res    (out_res),
    .out_max    (out_max),
    .out_acc    (out_acc)
  );

endmodule

/* tb_risk_top.sv */
`timescale 1ns/1ps
// testbench for risk_top that drives orders on the falling edge and checks each
// out_valid against a per-client reference model of the risk rule
// built and run through the Makefile with the verdict in the last line

module tb_risk_top;

  localparam int clk_half = 2;  // 4 ns period
  localparam int wd_cycles = 200 * (2 * risk_pkg::store_lat + 4) + 1000;
  localparam int n_clients = 2**risk_pkg::client_w;

  logic                          clk, rst, in_valid, in_ready, out_valid;
  risk_pkg::op_e                 in_op;
  logic [risk_pkg::client_w-1:0] in_client, out_client;
  logic [risk_pkg::amt_w-1:0]    in_amount, out_max, out_acc;
  risk_pkg::res_e                out_res;

  // model records and per-client expected results as {res, max, acc}
  logic [risk_pkg::amt_w-1:0]   m_max [n_clients];
  logic [risk_pkg::amt_w-1:0]   m_acc [n_clients];
  logic [risk_pkg::rec_w+1:0]   exp_q [n_clients][$];

  int    errors, checks, n_accepted, n_results;
  string test_name;

  risk_top u_dut (
    .clk(clk), .rst(rst), .in_valid(in_valid), .in_op(in_op), .in_client(in_client),
    .in_amount(in_amount), .in_ready(in_ready), .out_valid(out_valid),
    .out_client(out_client), .out_res(out_res), .out_max(out_max), .out_acc(out_acc)
  );

  initial begin
    clk = 1'b0;
    forever #clk_half clk = ~clk;
  end

  // ends a hung run
  initial begin
    repeat (wd_cycles) @(posedge clk);
    $display("timeout after %0d cycles, results still missing in %s", wd_cycles, test_name);
    $display("SIMULATION FAILED");
    $finish;
  end

  // first edge out of reset
  a_after_reset: assert property (@(posedge clk) $fell(rst) |-> (in_ready && !out_valid))
    else begin
      errors++;
      $display("in_ready low or out_valid high right after reset");
    end

  // no result without an accepted order behind it
  a_no_spurious: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> (n_results <= n_accepted))
    else begin
      errors++;
      $display("out_valid fired with no order outstanding");
    end

  // result monitor samples mid-cycle where the registered outputs are stable
  always @(negedge clk) begin
    logic [risk_pkg::rec_w+1:0] want;
    if (!rst && out_valid) begin
      n_results++;
      if (exp_q[out_client].size() == 0) begin
        errors++;
        $display("result for client %0d arrived with an empty queue", out_client);
      end else begin
        want = exp_q[out_client].pop_front();
        checks++;
        assert (out_res == risk_pkg::res_e'(want[risk_pkg::rec_w +: 2])) else begin
          errors++;
          $display("FAIL %s client %0d res expected %0d actual %0d", test_name,
                   out_client, want[risk_pkg::rec_w +: 2], out_res);
        end
        assert (out_max == want[risk_pkg::amt_w +: risk_pkg::amt_w]) else begin
          errors++;
          $display("FAIL %s client %0d max expected %0d actual %0d", test_name,
                   out_client, want[risk_pkg::amt_w +: risk_pkg::amt_w], out_max);
        end
        assert (out_acc == want[risk_pkg::amt_w-1:0]) else begin
          errors++;
          $display("FAIL %s client %0d acc expected %0d actual %0d", test_name,
                   out_client, want[risk_pkg::amt_w-1:0], out_acc);
        end
      end
    end
  end

  // model risk rule with results queued in acceptance order
  task automatic apply_model(input risk_pkg::op_e op, input logic [7:0] c,
                             input logic [15:0] a);
    logic [16:0]    sum;
    risk_pkg::res_e res;
    sum = {1'b0, m_acc[c]} + {1'b0, a};  // 17 bits so no wrap
    res = risk_pkg::res_info;
    if (op == risk_pkg::op_set_max) begin
      m_max[c] = a;
      res      = risk_pkg::res_accept;
    end else if (op == risk_pkg::op_add_order) begin
      if (sum <= {1'b0, m_max[c]}) begin
        m_acc[c] = sum[15:0];
        res      = risk_pkg::res_accept;
      end else begin
        res = risk_pkg::res_reject;  // record left alone
      end
    end
    exp_q[c].push_back({res, m_max[c], m_acc[c]});
  endtask

  // hold the order until in_ready, then drop in_valid a cycle later
  task automatic submit_order(input risk_pkg::op_e op, input logic [7:0] c,
                              input logic [15:0] a);
    @(negedge clk);
    in_valid  = 1'b1;
    in_op     = op;
    in_client = c;
    in_amount = a;
    #1;  // in_ready settles
    while (!in_ready) begin
      @(negedge clk);
      #1;
    end
    apply_model(op, c, a);  // taken on the coming rising edge
    n_accepted++;
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic drain();
    while (n_results != n_accepted) @(negedge clk);
    repeat (8) @(negedge clk);  // window for a stray out_valid
  endtask

  initial begin
    logic [31:0]   r_op, r_cli, r_amt, r_gap;
    risk_pkg::op_e r_sel;
    logic [7:0]    ev;
    integer        seed;
    seed = 32'he8ce;
    errors = 0;
    checks = 0;
    n_accepted = 0;
    n_results = 0;
    rst = 1'b1;
    in_valid = 1'b0;
    in_op = risk_pkg::op_query;
    in_client = '0;
    in_amount = '0;
    test_name = "reset";
    for (int c = 0; c < n_clients; c++) begin
      m_max[c] = '0;
      m_acc[c] = '0;
    end
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    assert (in_ready === 1'b1 && out_valid === 1'b0) else begin
      errors++;
      $display("in_ready not high or out_valid not low after reset");
    end

    // store is all zero so any client reads back 0/0
    submit_order(risk_pkg::op_query, 8'd0, 16'd0);
    submit_order(risk_pkg::op_query, 8'd1, 16'd0);
    submit_order(risk_pkg::op_query, 8'd2, 16'd0);
    submit_order(risk_pkg::op_query, 8'd37, 16'd0);
    submit_order(risk_pkg::op_query, 8'd255, 16'd0);
    drain();

    test_name = "within_limit";
    submit_order(risk_pkg::op_set_max, 8'd5, 16'd1000);
    submit_order(risk_pkg::op_add_order, 8'd5, 16'd100);
    submit_order(risk_pkg::op_add_order, 8'd5, 16'd250);
    submit_order(risk_pkg::op_add_order, 8'd5, 16'd400);  // acc 750
    drain();

    test_name = "over_limit";
    submit_order(risk_pkg::op_add_order, 8'd5, 16'd300);  // 1050 > 1000
    submit_order(risk_pkg::op_set_max, 8'd5, 16'd2000);   // acc stays 750
    submit_order(risk_pkg::op_add_order, 8'd5, 16'd300);
    submit_order(risk_pkg::op_set_max, 8'd9, 16'hffff);
    submit_order(risk_pkg::op_add_order, 8'd9, 16'hfff0);
    submit_order(risk_pkg::op_add_order, 8'd9, 16'h0020); // carry out of 16 bits
    drain();

    // same bank and index with tags 0..3 so each one evicts a dirty line
    test_name = "eviction";
    for (int i = 0; i < 4; i++) begin
      ev = 8'(6 + 32 * i);
      submit_order(risk_pkg::op_set_max, ev, 16'(500 + 100 * i));
    end
    for (int r = 0; r < 3; r++) begin
      for (int i = 0; i < 4; i++) begin
        ev = 8'(6 + 32 * i);
        submit_order(risk_pkg::op_add_order, ev, 16'(10 + 7 * r + i));
      end
    end
    for (int i = 0; i < 4; i++) begin
      ev = 8'(6 + 32 * i);
      submit_order(risk_pkg::op_query, ev, 16'd0);
    end
    drain();

    test_name = "random";
    for (int n = 0; n < 120; n++) begin
      r_op  = $random(seed);
      r_cli = $random(seed);
      r_amt = $random(seed);
      r_gap = $random(seed);
      case (r_op[1:0])
        2'd0:    r_sel = risk_pkg::op_set_max;
        2'd3:    r_sel = risk_pkg::op_query;
        default: r_sel = risk_pkg::op_add_order;  // adds twice as likely
      endcase
      repeat (r_gap[1:0]) @(negedge clk);  // random idle cycles
      if (r_sel == risk_pkg::op_set_max) begin
        submit_order(r_sel, r_cli[7:0], {4'h0, r_amt[11:0]});
      end else begin
        submit_order(r_sel, r_cli[7:0], {8'h00, r_amt[7:0]});
      end
    end
    drain();

    for (int c = 0; c < n_clients; c++) begin
      if (exp_q[c].size() != 0) begin
        errors++;
        $display("client %0d still waits for %0d results", c, exp_q[c].size());
      end
    end
    if (n_results != n_accepted) begin
      errors++;
      $display("accepted %0d orders but saw %0d results", n_accepted, n_results);
    end
    $display("summary errors %0d checks %0d accepted %0d results %0d",
             errors, checks, n_accepted, n_results);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
